//--- Makefile
TOOL     = verilator
FLAGS    = --timing
TOP      = fetch_tb
FILELIST = vlog.f
OBJDIR   = obj_dir
PASS     = All tests passed

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS)"

clean:
	rm -rf $(OBJDIR)

//--- sim/fetch_tb.sv
module fetch_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import fetch_pkg::*;

  logic clk_in = 1'b0;
  logic rst_in, inst_valid, resolve_valid, resolve_taken, redirect_valid, jalr_done, issue_ready;
  logic [31:0] inst, resolve_pc, redirect_addr, jalr_addr, fetch_addr;
  logic issue_valid;
  uop_t issue_uop;

  logic [31:0] mem [64];    // instruction memory, word indexed
  logic [31:0] prog_end;    // no valid word at or past this address
  logic fetch_en, gate, rand_mode;
  logic [1:0] ref_bht [16]; // shadow of the predictor table
  uop_t exp_q [$];          // expected issue stream
  uop_t exp_u;
  int err_cnt = 0;
  int err_mark, tests_run = 0, tests_failed = 0, checked = 0;

  fetch_top UUT (.*);

  always #50 clk_in = ~clk_in;

  // combinational memory, answers the current fetch address
  assign inst       = mem[fetch_addr[7:2]];
  assign inst_valid = fetch_en && gate && (fetch_addr < prog_end);

  // random stalls on both sides, changed just after the edge
  always @(posedge clk_in) begin
    #1;
    if (rand_mode) begin
      gate        = ($urandom % 4) != 0;
      issue_ready = ($urandom % 3) != 0;
    end
  end

  task automatic check_val(input string name, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  // pops happen on the next edge, values here are settled
  always @(negedge clk_in) begin
    if (!rst_in && issue_valid && issue_ready) begin
      if (exp_q.size() == 0) begin
        err_cnt++;
        $display("unexpected micro-op issued at pc 0x%0h", issue_uop.pc);
      end else begin
        exp_u = exp_q.pop_front();
        checked++;
        check_val("issue_uop.pc", 128'(issue_uop.pc), 128'(exp_u.pc));
        check_val("issue_uop.op", 128'(issue_uop.op), 128'(exp_u.op));
        check_val("issue_uop.pred_taken", 128'(issue_uop.pred_taken), 128'(exp_u.pred_taken));
        check_val("issue_uop", 128'(issue_uop), 128'(exp_u));
      end
    end
  end

  // expected micro-op straight from the rv32i encoding
  function automatic uop_t ref_decode(logic [31:0] w, logic [31:0] pc, logic pred);
    uop_t u;
    u          = '0;
    u.funct3   = w[14:12];
    u.funct7b5 = w[30];
    u.rd       = w[11:7];
    u.rs1      = w[19:15];
    u.rs2      = w[24:20];
    u.pc       = pc;
    u.use_imm  = 1'b1;
    case (w[6:0])
      7'h37: begin
        u.op  = OP_LUI;
        u.imm = {w[31:12], 12'h000};
      end
      7'h17: begin
        u.op  = OP_AUIPC;
        u.imm = {w[31:12], 12'h000};
      end
      7'h6f: begin
        u.op  = OP_JAL;
        u.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      end
      7'h67: begin
        u.op  = OP_JALR;
        u.imm = {{21{w[31]}}, w[30:20]};
      end
      7'h63: begin
        u.op         = OP_BRANCH;
        u.use_imm    = 1'b0;
        u.imm        = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        u.pred_taken = pred;  // only branches take the bht bit
      end
      7'h03: begin
        u.op  = OP_LOAD;
        u.imm = {{21{w[31]}}, w[30:20]};
      end
      7'h23: begin
        u.op  = OP_STORE;
        u.imm = {{21{w[31]}}, w[30:25], w[11:7]};
      end
      7'h13: begin
        u.op  = OP_ALUI;
        u.imm = {{21{w[31]}}, w[30:20]};
      end
      7'h33: begin
        u.op      = OP_ALU;
        u.use_imm = 1'b0;
      end
      default: begin
        u.op      = OP_ILLEGAL;
        u.use_imm = 1'b0;
      end
    endcase
    return u;
  endfunction

  // walk the program like the fetch unit would, stop after a jalr
  task automatic predict_stream(input logic [31:0] start);
    logic [31:0] pc;
    uop_t u;
    pc = start;
    for (int n = 0; n < 64 && pc < prog_end; n++) begin
      u = ref_decode(mem[pc[7:2]], pc, ref_bht[pc[5:2]][1]);
      exp_q.push_back(u);
      if (u.op == OP_JALR) break;
      pc = (u.op == OP_JAL || u.pred_taken) ? pc + u.imm : pc + 32'd4;
    end
  endtask

  task automatic fill_addi();
    for (int i = 0; i < 64; i++) mem[i] = {12'(i), 20'h08093};  // addi x1, x1, i
  endtask

  function automatic logic [31:0] rand_word();
    logic [31:0] w;
    int sel;
    w   = $urandom();
    sel = $urandom % 5;
    case (sel)
      0: w[6:0] = 7'h33;
      1: w[6:0] = 7'h13;
      2: w[6:0] = 7'h03;
      3: w[6:0] = 7'h23;
      default: w[6:0] = 7'h37;
    endcase
    return w;
  endfunction

  task automatic do_reset();
    rst_in = 1'b1;
    {fetch_en, rand_mode, resolve_valid, resolve_taken, redirect_valid, jalr_done} = '0;
    gate = 1'b1;
    issue_ready = 1'b1;
    {resolve_pc, redirect_addr, jalr_addr} = '0;
    exp_q.delete();
    foreach (ref_bht[i]) ref_bht[i] = 2'b01;  // weakly not-taken
    fill_addi();
    repeat (3) @(posedge clk_in);
    #1 rst_in = 1'b0;
  endtask

  task automatic train(input logic [31:0] pc, input logic taken);
    resolve_valid = 1'b1;
    resolve_pc    = pc;
    resolve_taken = taken;
    if (taken && ref_bht[pc[5:2]] != 2'b11) ref_bht[pc[5:2]] += 2'd1;
    else if (!taken && ref_bht[pc[5:2]] != 2'b00) ref_bht[pc[5:2]] -= 2'd1;
    @(posedge clk_in);
    #1 resolve_valid = 1'b0;
  endtask

  task automatic wait_drain(input int max_cycles);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < max_cycles) begin
      @(posedge clk_in);
      n++;
    end
    if (exp_q.size() != 0) begin
      err_cnt++;
      $display("timeout: %0d expected micro-ops never issued", exp_q.size());
    end
    repeat (8) @(posedge clk_in);  // idle window, any extra issue is flagged
    #1;
  endtask

  task automatic wait_addr(input logic [31:0] addr, input int max_cycles);
    int n;
    n = 0;
    while (fetch_addr !== addr && n < max_cycles) begin
      @(posedge clk_in);
      n++;
    end
    #1;
    if (fetch_addr !== addr) begin
      err_cnt++;
      $display("timeout: fetch never reached address 0x%0h", addr);
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (err_cnt != err_mark) tests_failed++;
    $display("test %0d %s: %s", tests_run, name, (err_cnt != err_mark) ? "FAIL" : "ok");
    err_mark = err_cnt;  // next test counts from here
  endtask

  initial begin
    int seed_ret;
    seed_ret = $urandom(32'h775c);
    err_mark = 0;
    fill_addi();
    prog_end = '0;
    do_reset();
    // add, addi, lw, sw, lui, auipc, then a junk word
    mem[0] = 32'h002081b3;
    mem[1] = 32'hffd00293;
    mem[2] = 32'h00812303;
    mem[3] = 32'hfe712e23;
    mem[4] = 32'h12345437;
    mem[5] = 32'hfffff497;
    mem[6] = 32'hffffffff;
    prog_end = 32'h1c;
    predict_stream(0);
    fetch_en = 1'b1;
    wait_drain(100);
    end_test("straight line");

    do_reset();
    mem[1]   = 32'h00c000ef;  // jal x1, +12
    prog_end = 32'h20;
    predict_stream(0);
    fetch_en = 1'b1;
    wait_drain(100);
    end_test("jal");

    do_reset();
    mem[1]   = 32'h000280e7;  // jalr x1, 0(x5)
    prog_end = 32'h40;
    predict_stream(0);
    fetch_en = 1'b1;
    wait_drain(100);
    for (int i = 0; i < 10; i++) begin
      check_val("issue_valid", 128'(issue_valid), 128'(0));
      check_val("fetch_addr", 128'(fetch_addr), 128'(32'h8));
      @(posedge clk_in);
      #1;
    end
    predict_stream(32'h20);
    jalr_addr = 32'h20;
    jalr_done = 1'b1;
    @(posedge clk_in);
    #1 jalr_done = 1'b0;
    wait_drain(100);
    end_test("jalr stall");

    do_reset();
    for (int i = 0; i < 40; i++) mem[i] = rand_word();
    prog_end = 32'd160;
    predict_stream(0);
    rand_mode = 1'b1;
    fetch_en  = 1'b1;
    wait_drain(1000);
    rand_mode   = 1'b0;
    gate        = 1'b1;
    issue_ready = 1'b1;
    end_test("random stalls");

    do_reset();
    mem[2]   = 32'h00208863;  // beq x1, x2, +16
    prog_end = 32'h20;
    predict_stream(0);  // untrained, falls through
    fetch_en = 1'b1;
    wait_drain(100);
    do_reset();
    mem[2]   = 32'h00208863;
    prog_end = 32'h20;
    train(32'h8, 1'b1);
    train(32'h8, 1'b1);
    predict_stream(0);  // now jumps to 0x18
    fetch_en = 1'b1;
    wait_drain(100);
    end_test("branch prediction");

    do_reset();
    prog_end    = 32'h40;
    issue_ready = 1'b0;
    fetch_en    = 1'b1;
    wait_addr(32'h10, 50);  // queue full, fetch held
    redirect_valid = 1'b1;
    redirect_addr  = 32'h28;
    @(posedge clk_in);
    #1 redirect_valid = 1'b0;
    check_val("issue_valid", 128'(issue_valid), 128'(0));
    predict_stream(32'h28);
    issue_ready = 1'b1;
    wait_drain(100);
    end_test("redirect flush");

    $display("%0d tests, %0d failed, %0d micro-ops checked, %0d errors",
             tests_run, tests_failed, checked, err_cnt);
    if (err_cnt == 0 && tests_failed == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- source/branch_predictor.sv
module branch_predictor (
  input  logic                       clk_in,
  input  logic                       rst_in,
  input  logic [fetch_pkg::XLEN-1:0] lookup_pc,
  input  logic                       resolve_valid,
  input  logic [fetch_pkg::XLEN-1:0] resolve_pc,
  input  logic                       resolve_taken,
  output logic                       predict_taken
);
  import fetch_pkg::*;

  logic [1:0]           bht [BHT_ENTRIES];  // 2-bit saturating counters
  logic [BHT_IDX_W-1:0] lookup_idx;
  logic [BHT_IDX_W-1:0] resolve_idx;
  logic [1:0]           cur_cnt;

  // word-aligned pc, drop bits 1:0
  assign lookup_idx  = lookup_pc[BHT_IDX_W+1:2];
  assign resolve_idx = resolve_pc[BHT_IDX_W+1:2];
  assign cur_cnt     = bht[resolve_idx];

  assign predict_taken = bht[lookup_idx][1];  // upper bit set means taken

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      for (int i = 0; i < BHT_ENTRIES; i++) begin
        bht[i] <= 2'b01;  // weakly not-taken
      end
    end else if (resolve_valid) begin
      if (resolve_taken) begin
        if (cur_cnt != 2'b11) begin
          bht[resolve_idx] <= cur_cnt + 2'd1;
        end
      end else if (cur_cnt != 2'b00) begin
        bht[resolve_idx] <= cur_cnt - 2'd1;
      end
    end
  end

endmodule

//--- source/fetch_if.sv
// micro-op push channel from fetch into the queue,
// credit pulses flowing back the other way
interface fetch_if;
  import fetch_pkg::*;

  logic push;    // one cycle per micro-op
  uop_t entry;   // valid with push
  logic credit;  // one cycle per pop

  modport producer (
    output push,
    output entry,
    input  credit
  );

  modport consumer (
    input  push,
    input  entry,
    output credit
  );

endinterface

//--- source/fetch_pkg.sv
package fetch_pkg;

  localparam int XLEN        = 32;  // data and address width
  localparam int FQ_DEPTH    = 4;   // queue entries, also credits after reset
  localparam int FQ_CNT_W    = 3;   // holds 0..FQ_DEPTH
  localparam int FQ_PTR_W    = 2;   // circular buffer pointer width
  localparam int BHT_ENTRIES = 16;
  localparam int BHT_IDX_W   = 4;   // pc[5:2]

  // raw rv32i major opcodes, low two bits always 11
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_ALUI   = 7'b0010011,
    OPC_ALU    = 7'b0110011
  } opcode_e;

  // op class carried by a micro-op
  typedef enum logic [3:0] {
    OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_BRANCH,
    OP_LOAD, OP_STORE, OP_ALUI, OP_ALU, OP_ILLEGAL
  } op_e;

  typedef struct packed {
    op_e             op;
    logic [2:0]      funct3;
    logic            funct7b5;    // sub/sra select
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic            use_imm;     // operand b from imm
    logic [XLEN-1:0] imm;         // sign-extended
    logic [XLEN-1:0] pc;
    logic            pred_taken;  // bht said taken at fetch
  } uop_t;

endpackage

//--- source/fetch_queue.sv
module fetch_queue (
  input  logic            clk_in,
  input  logic            rst_in,
  input  logic            flush,
  input  logic            issue_ready,
  output logic            issue_valid,
  output fetch_pkg::uop_t issue_uop,
  fetch_if.consumer       fq
);
  import fetch_pkg::*;

  uop_t                mem [FQ_DEPTH];
  logic [FQ_PTR_W-1:0] wr_ptr;
  logic [FQ_PTR_W-1:0] rd_ptr;
  logic [FQ_CNT_W-1:0] count;  // occupancy
  logic                pop;

  assign issue_valid = (count != '0);
  assign issue_uop   = mem[rd_ptr];
  assign pop         = issue_valid && issue_ready;
  assign fq.credit   = pop;  // one slot back to fetch

  // payload, credits guarantee a free slot
  always_ff @(posedge clk_in) begin
    if (fq.push) begin
      mem[wr_ptr] <= fq.entry;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in || flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (fq.push) wr_ptr <= wr_ptr + 1'b1;  // wraps at FQ_DEPTH
      if (pop)     rd_ptr <= rd_ptr + 1'b1;
      case ({fq.push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- source/fetch_top.sv
module fetch_top (
  input  logic                       clk_in,
  input  logic                       rst_in,
  input  logic [fetch_pkg::XLEN-1:0] inst,
  input  logic                       inst_valid,
  input  logic                       resolve_valid,
  input  logic [fetch_pkg::XLEN-1:0] resolve_pc,
  input  logic                       resolve_taken,
  input  logic                       redirect_valid,
  input  logic [fetch_pkg::XLEN-1:0] redirect_addr,
  input  logic                       jalr_done,
  input  logic [fetch_pkg::XLEN-1:0] jalr_addr,
  input  logic                       issue_ready,
  output logic [fetch_pkg::XLEN-1:0] fetch_addr,
  output logic                       issue_valid,
  output fetch_pkg::uop_t            issue_uop
);
  import fetch_pkg::*;

  logic [XLEN-1:0] lookup_pc;
  logic            predict_taken;

  fetch_if fq_bus ();  // fetch to queue, credits back

  branch_predictor u_bp (
    .clk_in        (clk_in),
    .rst_in        (rst_in),
    .lookup_pc     (lookup_pc),
    .resolve_valid (resolve_valid),
    .resolve_pc    (resolve_pc),
    .resolve_taken (resolve_taken),
    .predict_taken (predict_taken)
  );

  fetch_unit u_fetch (
    .clk_in         (clk_in),
    .rst_in         (rst_in),
    .inst           (inst),
    .inst_valid     (inst_valid),
    .predict_taken  (predict_taken),
    .redirect_valid (redirect_valid),
    .redirect_addr  (redirect_addr),
    .jalr_done      (jalr_done),
    .jalr_addr      (jalr_addr),
    .fetch_addr     (fetch_addr),
    .lookup_pc      (lookup_pc),
    .fq             (fq_bus.producer)
  );

  fetch_queue u_fq (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .flush       (redirect_valid),  // mispredict empties the queue
    .issue_ready (issue_ready),
    .issue_valid (issue_valid),
    .issue_uop   (issue_uop),
    .fq          (fq_bus.consumer)
  );

endmodule

//--- source/fetch_unit.sv
module fetch_unit (
  input  logic                       clk_in,
  input  logic                       rst_in,
  input  logic [fetch_pkg::XLEN-1:0] inst,
  input  logic                       inst_valid,
  input  logic                       predict_taken,
  input  logic                       redirect_valid,
  input  logic [fetch_pkg::XLEN-1:0] redirect_addr,
  input  logic                       jalr_done,
  input  logic [fetch_pkg::XLEN-1:0] jalr_addr,
  output logic [fetch_pkg::XLEN-1:0] fetch_addr,
  output logic [fetch_pkg::XLEN-1:0] lookup_pc,
  fetch_if.producer                  fq
);
  import fetch_pkg::*;

  logic [XLEN-1:0]     pc;
  logic [XLEN-1:0]     pc_next;
  logic                jalr_pend;  // waiting on jalr target
  logic [FQ_CNT_W-1:0] credits;    // free queue slots
  logic                accept;
  logic                br_taken;
  uop_t                dec_uop;
  uop_t                push_uop;

  inst_decoder u_dec (
    .inst (inst),
    .uop  (dec_uop)
  );

  assign fetch_addr = pc;
  assign lookup_pc  = pc;  // bht looked up with the word being fetched

  // take the word this cycle
  assign accept   = inst_valid && (credits != '0) && !jalr_pend && !redirect_valid;
  assign br_taken = (dec_uop.op == OP_BRANCH) && predict_taken;

  always_comb begin
    push_uop            = dec_uop;
    push_uop.pc         = pc;
    push_uop.pred_taken = br_taken;  // only branches carry a prediction
  end

  assign fq.push  = accept;
  assign fq.entry = push_uop;

  // next pc, priority order
  always_comb begin
    pc_next = pc;  // hold when stalled
    if (redirect_valid) begin
      pc_next = redirect_addr;
    end else if (jalr_pend && jalr_done) begin
      pc_next = jalr_addr;
    end else if (accept) begin
      if (dec_uop.op == OP_JAL || br_taken) begin
        pc_next = pc + dec_uop.imm;
      end else begin
        pc_next = pc + XLEN'(4);
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      pc        <= '0;
      jalr_pend <= 1'b0;
    end else begin
      pc <= pc_next;
      if (redirect_valid) begin
        jalr_pend <= 1'b0;  // redirect drops the pending jalr
      end else if (accept && dec_uop.op == OP_JALR) begin
        jalr_pend <= 1'b1;
      end else if (jalr_done) begin
        jalr_pend <= 1'b0;
      end
    end
  end

  // credit counter, flush refills it without credit pulses
  always_ff @(posedge clk_in) begin
    if (rst_in || redirect_valid) begin
      credits <= FQ_CNT_W'(FQ_DEPTH);
    end else begin
      case ({fq.push, fq.credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;  // none, or both cancel
      endcase
    end
  end

endmodule

//--- source/inst_decoder.sv
module inst_decoder (
  input  logic [fetch_pkg::XLEN-1:0] inst,
  output fetch_pkg::uop_t            uop
);
  import fetch_pkg::*;

  opcode_e         opcode;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;

  assign opcode = opcode_e'(inst[6:0]);

  // immediates by format, all sign-extended from inst[31]
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    uop          = '0;  // pc and pred_taken stay zero here
    uop.funct3   = inst[14:12];
    uop.funct7b5 = inst[30];
    uop.rd       = inst[11:7];
    uop.rs1      = inst[19:15];
    uop.rs2      = inst[24:20];
    case (opcode)
      OPC_LUI: begin
        uop.op      = OP_LUI;
        uop.use_imm = 1'b1;
        uop.imm     = imm_u;
      end
      OPC_AUIPC: begin
        uop.op      = OP_AUIPC;
        uop.use_imm = 1'b1;
        uop.imm     = imm_u;
      end
      OPC_JAL: begin
        uop.op      = OP_JAL;
        uop.use_imm = 1'b1;
        uop.imm     = imm_j;  // jump offset
      end
      OPC_JALR: begin
        uop.op      = OP_JALR;
        uop.use_imm = 1'b1;
        uop.imm     = imm_i;
      end
      OPC_BRANCH: begin
        uop.op  = OP_BRANCH;  // compares rs1/rs2, imm only for target
        uop.imm = imm_b;
      end
      OPC_LOAD: begin
        uop.op      = OP_LOAD;
        uop.use_imm = 1'b1;
        uop.imm     = imm_i;
      end
      OPC_STORE: begin
        uop.op      = OP_STORE;
        uop.use_imm = 1'b1;
        uop.imm     = imm_s;
      end
      OPC_ALUI: begin
        uop.op      = OP_ALUI;
        uop.use_imm = 1'b1;
        uop.imm     = imm_i;  // shamt sits in the low bits
      end
      OPC_ALU:  uop.op = OP_ALU;
      default:  uop.op = OP_ILLEGAL;  // passed on, imm left zero
    endcase
  end

endmodule

//--- vlog.f
source/fetch_pkg.sv
source/fetch_if.sv
source/inst_decoder.sv
source/branch_predictor.sv
source/fetch_unit.sv
source/fetch_queue.sv
source/fetch_top.sv
sim/fetch_tb.sv
